//--- rtl/mips_pkg.sv
// Shared widths, instruction encodings and stage records for the multicycle MIPS core
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////
    // Widths and memory sizes
    ////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    // One RAM shape serves both memories
    localparam int MEM_WORDS  = (IMEM_WORDS > DMEM_WORDS) ? IMEM_WORDS : DMEM_WORDS;
    localparam int MEM_AW     = $clog2(MEM_WORDS);     // Word index width
    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31;  // JAL link register

    ////////////////////////////////////////
    // Opcodes and function codes
    ////////////////////////////////////////
    localparam logic [5:0] OP_SPECIAL = 6'b000000;  // R-type table
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    // J target is {rs, rt, imm16} of this view
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  op2_imm;       // Immediate as operand 2
        logic                  imm_zero_ext;  // Logical ops zero-extend
        logic                  is_branch;
        logic                  branch_ne;     // BNE polarity
        logic                  is_jump;
        logic                  is_jal;
        logic                  is_jr;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] dest;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] result;      // ALU result, address or link value
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] next_pc;
        logic            update_pc;
    } exec_t;

    typedef struct packed {
        logic            en;
        logic            we;
        logic [XLEN-1:0] addr;        // Byte address, word aligned
        logic [XLEN-1:0] data;
    } load_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       value;
    } retire_t;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB
    } state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
// Program counter with next-PC selection once per instruction at writeback
`default_nettype none

module fetch_unit import mips_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   hold,     // Memory loading in progress
    input  wire state_t state,
    input  wire exec_t  exec,     // Held execute result
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pc_seq;

    assign pc_seq = pc + XLEN'(4);  // Sequential address

    ////////////////////////////////////////
    // PC register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || hold) begin
            pc <= '0;  // Restart from word 0 after loading
        end else if (state == S_WB) begin
            // Resolved target or fall-through
            if (exec.update_pc) begin
                pc <= exec.next_pc;
            end else begin
                pc <= pc_seq;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
// Opcode and function decode into the control record
`default_nettype none

module instr_decoder import mips_pkg::*; (
    input  wire instr_t instr,
    output ctrl_t       ctrl
);

    always_comb begin
        // Defaults give a no-op with nothing written
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.dest   = instr.i.rt;  // I-type destination

        case (instr.r.opcode)
            OP_SPECIAL: begin
                ctrl.dest      = instr.r.rd;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT, FN_SLTU: ctrl.alu_op = ALU_SLT;  // Both compare signed
                    FN_SLL:          ctrl.alu_op = ALU_SLL;
                    FN_SRL:          ctrl.alu_op = ALU_SRL;
                    FN_JR: begin
                        ctrl.is_jr     = 1'b1;  // Target comes from rs
                        ctrl.reg_write = 1'b0;
                    end
                    default:         ctrl.reg_write = 1'b0;  // Unknown funct
                endcase
            end

            ////////////////////////////////////////
            // Jumps and branches
            ////////////////////////////////////////
            OP_J: begin
                ctrl.is_jump = 1'b1;
            end
            OP_JAL: begin
                ctrl.is_jump   = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = RA_REG;  // Link into r31
            end
            OP_BEQ, OP_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.alu_op    = ALU_SUB;  // Zero result means equal
                ctrl.branch_ne = (instr.i.opcode == OP_BNE);
            end

            ////////////////////////////////////////
            // Immediate arithmetic and logic
            ////////////////////////////////////////
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (instr.i.opcode)
                    OP_SLTI, OP_SLTIU: ctrl.alu_op = ALU_SLT;
                    OP_ANDI:           ctrl.alu_op = ALU_AND;
                    OP_ORI:            ctrl.alu_op = ALU_OR;
                    OP_XORI:           ctrl.alu_op = ALU_XOR;
                    OP_LUI:            ctrl.alu_op = ALU_LUI;
                    default:           ctrl.alu_op = ALU_ADD;
                endcase
                // Logical ops and LUI take the raw 16 bits
                ctrl.imm_zero_ext = (instr.i.opcode == OP_ANDI) ||
                                    (instr.i.opcode == OP_ORI)  ||
                                    (instr.i.opcode == OP_XORI) ||
                                    (instr.i.opcode == OP_LUI);
            end

            ////////////////////////////////////////
            // Word memory access
            ////////////////////////////////////////
            OP_LW: begin
                ctrl.op2_imm   = 1'b1;  // rs + offset
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_SW: begin
                ctrl.op2_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end

            default: ;  // Unlisted opcode retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// 32 by 32 register file with register 0 hardwired to zero
`default_nettype none

module reg_file import mips_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [REG_ADDR_W-1:0] rs_addr,
    input  wire logic [REG_ADDR_W-1:0] rt_addr,
    input  wire logic                  we,
    input  wire logic [REG_ADDR_W-1:0] wr_addr,
    input  wire logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]            rs_data,
    output logic [XLEN-1:0]            rt_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];  // No storage behind index 0

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // Writes to r0 dropped
        end
    end

    // Asynchronous reads
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
// ALU, operand select, branch resolution and jump target computation
`default_nettype none

module execute_unit import mips_pkg::*; (
    input  wire logic [XLEN-1:0] pc,
    input  wire instr_t          instr,
    input  wire ctrl_t           ctrl,
    input  wire logic [XLEN-1:0] rs_data,
    input  wire logic [XLEN-1:0] rt_data,
    output exec_t                exec
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] jump_target;
    logic            taken;

    assign pc_plus4 = pc + XLEN'(4);
    assign imm_ext  = ctrl.imm_zero_ext ? {{(XLEN-16){1'b0}}, instr.i.imm16}
                                        : {{(XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};
    assign op2      = ctrl.op2_imm ? imm_ext : rt_data;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_res = rs_data + op2;
            ALU_SUB: alu_res = rs_data - op2;
            ALU_SLT: alu_res = XLEN'($signed(rs_data) < $signed(op2));
            ALU_AND: alu_res = rs_data & op2;
            ALU_OR:  alu_res = rs_data | op2;
            ALU_XOR: alu_res = rs_data ^ op2;
            ALU_SLL: alu_res = op2 << instr.r.shamt;  // Shifts act on rt
            ALU_SRL: alu_res = op2 >> instr.r.shamt;
            ALU_LUI: alu_res = op2 << 16;
            default: alu_res = '0;
        endcase
    end

    // Branch taken on zero difference, inverted for BNE
    assign taken       = ctrl.is_branch && ((alu_res == '0) != ctrl.branch_ne);
    assign br_target   = pc_plus4 + {imm_ext[XLEN-3:0], 2'b00};
    // Region bits of PC+4 with the word target
    assign jump_target = {pc_plus4[XLEN-1:28], instr.i.rs, instr.i.rt, instr.i.imm16, 2'b00};

    always_comb begin
        exec.result     = ctrl.is_jal ? pc_plus4 : alu_res;  // JAL links PC+4
        exec.store_data = rt_data;
        exec.update_pc  = taken || ctrl.is_jump || ctrl.is_jr;
        if (ctrl.is_jr) begin
            exec.next_pc = rs_data;
        end else if (ctrl.is_jump) begin
            exec.next_pc = jump_target;
        end else begin
            exec.next_pc = br_target;
        end
    end

endmodule

`default_nettype wire

//--- rtl/word_memory.sv
// Synchronous word RAM with a load port that takes over while loading
`default_nettype none

module word_memory import mips_pkg::*; (
    input  wire logic            clk,
    input  wire logic [XLEN-1:0] addr,   // Byte address from the core
    input  wire logic            we,
    input  wire logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0]      rdata,
    input  wire load_t           load
);

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;
    logic              wr_en;
    logic [XLEN-1:0]   wr_data;

    ////////////////////////////////////////
    // Port select
    ////////////////////////////////////////
    always_comb begin
        if (load.en) begin
            idx     = load.addr[MEM_AW+1:2];  // Loader owns the RAM
            wr_en   = load.we;
            wr_data = load.data;
        end else begin
            idx     = addr[MEM_AW+1:2];       // Drop byte offset, wrap on depth
            wr_en   = we;
            wr_data = wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= wr_data;
        end
        rdata <= mem[idx];  // Old data on a same-edge write
    end

endmodule

`default_nettype wire

//--- rtl/stage_sequencer.sv
// Five-state instruction sequencer with the decode, execute and writeback registers
`default_nettype none

module stage_sequencer import mips_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            hold,
    input  wire instr_t          fetch_word,  // IMEM output, valid in S_DECODE
    input  wire ctrl_t           ctrl,
    input  wire exec_t           exec_in,
    input  wire logic [XLEN-1:0] mem_rdata,   // DMEM output, valid in S_WB
    input  wire logic [XLEN-1:0] pc,
    output state_t               state,
    output instr_t               instr_reg,
    output exec_t                exec_reg,
    output logic                 dmem_we,
    output logic                 rf_we,
    output logic [XLEN-1:0]      rf_wdata,
    output retire_t              retire
);

    state_t state_nxt;

    always_comb begin
        case (state)
            S_FETCH:  state_nxt = S_DECODE;
            S_DECODE: state_nxt = S_EXEC;
            S_EXEC:   state_nxt = S_MEM;
            S_MEM:    state_nxt = S_WB;
            default:  state_nxt = S_FETCH;  // S_WB wraps around
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || hold) begin
            state <= S_FETCH;  // Parked while memories load
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == S_DECODE) instr_reg <= fetch_word;
        if (state == S_EXEC)   exec_reg  <= exec_in;  // Held through MEM and WB
    end

    assign dmem_we  = (state == S_MEM) && ctrl.mem_write;
    assign rf_we    = (state == S_WB) && ctrl.reg_write;
    assign rf_wdata = ctrl.mem_read ? mem_rdata : exec_reg.result;

    // Retire trace, one pulse per instruction
    always_comb begin
        retire.valid     = (state == S_WB);
        retire.pc        = pc;  // PC moves only after S_WB
        retire.reg_write = ctrl.reg_write;
        retire.dest      = ctrl.dest;
        retire.value     = rf_wdata;
    end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
// Multicycle MIPS core top with instruction and data memories
`default_nettype none

module mips_core import mips_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire load_t imem_load,
    input  wire load_t dmem_load,
    output retire_t    retire
);

    state_t          state;
    logic [XLEN-1:0] pc;
    instr_t          fetch_word;
    instr_t          instr_reg;
    ctrl_t           ctrl;
    exec_t           exec_now;   // Combinational execute result
    exec_t           exec_reg;   // Captured at end of S_EXEC
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] rf_wdata;
    logic            dmem_we;
    logic            rf_we;

    ////////////////////////////////////////
    // Fetch and sequencing
    ////////////////////////////////////////
    fetch_unit fetch_i (
        .clk(clk), .rst(rst), .hold(imem_load.en | dmem_load.en),
        .state(state), .exec(exec_reg), .pc(pc)
    );

    word_memory imem_i (
        .clk(clk), .addr(pc), .we(1'b0), .wdata({XLEN{1'b0}}),
        .rdata(fetch_word), .load(imem_load)
    );

    stage_sequencer seq_i (
        .clk(clk), .rst(rst), .hold(imem_load.en | dmem_load.en),
        .fetch_word(fetch_word), .ctrl(ctrl), .exec_in(exec_now), .mem_rdata(mem_rdata),
        .pc(pc), .state(state), .instr_reg(instr_reg), .exec_reg(exec_reg),
        .dmem_we(dmem_we), .rf_we(rf_we), .rf_wdata(rf_wdata), .retire(retire)
    );

    ////////////////////////////////////////
    // Decode, execute and data memory
    ////////////////////////////////////////
    instr_decoder dec_i (.instr(instr_reg), .ctrl(ctrl));

    reg_file rf_i (
        .clk(clk), .rst(rst), .rs_addr(instr_reg.r.rs), .rt_addr(instr_reg.r.rt),
        .we(rf_we), .wr_addr(ctrl.dest), .wr_data(rf_wdata),
        .rs_data(rs_data), .rt_data(rt_data)
    );

    execute_unit exe_i (
        .pc(pc), .instr(instr_reg), .ctrl(ctrl),
        .rs_data(rs_data), .rt_data(rt_data), .exec(exec_now)
    );

    word_memory dmem_i (
        .clk(clk), .addr(exec_reg.result), .we(dmem_we), .wdata(exec_reg.store_data),
        .rdata(mem_rdata), .load(dmem_load)
    );

endmodule

`default_nettype wire

//--- testbench/mips_checker.sv
// Reference instruction model that checks every retire record of the core
`default_nettype none

module mips_checker import mips_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire load_t   imem_load,
    input  wire load_t   dmem_load,
    input  wire retire_t retire,
    output int           checks,    // Retires compared
    output int           errors
);

    // Outcome of one model step
    typedef struct packed {
        retire_t         ret;
        logic [XLEN-1:0] next_pc;
        logic            store;
        logic [XLEN-1:0] st_addr;
        logic [XLEN-1:0] st_data;
    } step_t;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [XLEN-1:0] regs [32];          // Entry 0 is never written
    logic [XLEN-1:0] model_pc;

    ////////////////////////////////////////
    // Reference model, one instruction
    ////////////////////////////////////////
    function automatic step_t ref_step(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] iw);
        step_t           s;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sx;
        logic [XLEN-1:0] pc4;
        a   = regs[iw[25:21]];
        b   = regs[iw[20:16]];
        sx  = {{16{iw[15]}}, iw[15:0]};
        pc4 = pc + 32'd4;
        s               = '0;
        s.ret.valid     = 1'b1;
        s.ret.pc        = pc;
        s.ret.dest      = iw[20:16];  // rt unless R-type or JAL
        s.next_pc       = pc4;
        s.ret.reg_write = iw[31:26] inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                                           OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_JAL};
        case (iw[31:26])
            OP_SPECIAL: begin
                s.ret.dest      = iw[15:11];
                s.ret.reg_write = 1'b1;
                case (iw[5:0])
                    FN_ADD, FN_ADDU: s.ret.value = a + b;
                    FN_SUB, FN_SUBU: s.ret.value = a - b;
                    FN_SLT, FN_SLTU: s.ret.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:          s.ret.value = b << iw[10:6];
                    FN_SRL:          s.ret.value = b >> iw[10:6];
                    FN_JR: begin
                        s.ret.reg_write = 1'b0;
                        s.next_pc       = a;
                    end
                    default:         s.ret.reg_write = 1'b0;
                endcase
            end
            OP_J:   s.next_pc = {pc4[31:28], iw[25:0], 2'b00};
            OP_JAL: begin
                s.ret.dest  = RA_REG;
                s.ret.value = pc4;  // Link is the next sequential word
                s.next_pc   = {pc4[31:28], iw[25:0], 2'b00};
            end
            OP_BEQ:            if (a == b) s.next_pc = pc4 + (sx << 2);
            OP_BNE:            if (a != b) s.next_pc = pc4 + (sx << 2);
            OP_ADDI, OP_ADDIU: s.ret.value = a + sx;
            OP_SLTI, OP_SLTIU: s.ret.value = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_ANDI:           s.ret.value = a & {16'h0, iw[15:0]};
            OP_ORI:            s.ret.value = a | {16'h0, iw[15:0]};
            OP_XORI:           s.ret.value = a ^ {16'h0, iw[15:0]};
            OP_LUI:            s.ret.value = {iw[15:0], 16'h0};
            OP_LW:             s.ret.value = dmem[((a + sx) >> 2) % DMEM_WORDS];
            OP_SW: begin
                s.store   = 1'b1;
                s.st_addr = a + sx;
                s.st_data = b;
            end
            default: ;  // Anything else is a no-op
        endcase
        return s;
    endfunction

    task automatic report_mismatch(input string what, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] want);
        errors++;
        $display("Mismatch at %0t: %s is %h, expected %h (pc %h)", $time, what, got, want,
                 model_pc);
    endtask

    ////////////////////////////////////////
    // Snoop loads, step model, compare
    ////////////////////////////////////////
    always @(posedge clk) begin
        step_t exp;
        if (imem_load.en && imem_load.we) begin
            imem[(imem_load.addr >> 2) % IMEM_WORDS] = imem_load.data;
        end
        if (dmem_load.en && dmem_load.we) begin
            dmem[(dmem_load.addr >> 2) % DMEM_WORDS] = dmem_load.data;
        end
        if (rst) begin
            checks = 0;
            errors = 0;
            for (int i = 0; i < 32; i++) regs[i] = '0;
        end
        if (rst || imem_load.en || dmem_load.en) begin
            model_pc = '0;  // Core restarts at word 0
        end else if (retire.valid) begin
            exp = ref_step(model_pc, imem[(model_pc >> 2) % IMEM_WORDS]);
            checks++;
            if (retire.pc !== exp.ret.pc) report_mismatch("pc", retire.pc, exp.ret.pc);
            if (retire.reg_write !== exp.ret.reg_write) begin
                report_mismatch("reg_write", 32'(retire.reg_write), 32'(exp.ret.reg_write));
            end else if (exp.ret.reg_write) begin
                // Dest and value only mean something on a write
                if (retire.dest !== exp.ret.dest) begin
                    report_mismatch("dest", 32'(retire.dest), 32'(exp.ret.dest));
                end
                if (retire.value !== exp.ret.value) begin
                    report_mismatch("value", retire.value, exp.ret.value);
                end
            end
            if (exp.ret.reg_write && exp.ret.dest != '0) regs[exp.ret.dest] = exp.ret.value;
            if (exp.store) dmem[(exp.st_addr >> 2) % DMEM_WORDS] = exp.st_data;
            model_pc = exp.next_pc;
        end
    end

endmodule

`default_nettype wire

//--- testbench/mips_core_asserts.sv
// Concurrent checks on retire pacing, hold behavior and register 0
`default_nettype none

module mips_core_asserts import mips_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  hold,     // Either load port active
    input  wire retire_t               retire,
    input  wire logic                  rf_we,
    input  wire logic [REG_ADDR_W-1:0] wr_addr,
    input  wire logic [XLEN-1:0]       rs_data
);

    int fail_count = 0;  // Read by the testbench top

    ////////////////////////////////////////
    // Retire pacing
    ////////////////////////////////////////
    first_retire: assert property (@(posedge clk) disable iff (rst || hold)
        $past(rst || hold) |-> !retire.valid [*4] ##1 retire.valid)
        else begin
            fail_count++;
            $error("First retire not 5 cycles after release");
        end

    retire_spacing: assert property (@(posedge clk) disable iff (rst || hold)
        retire.valid |=> !retire.valid [*4] ##1 retire.valid)
        else begin
            fail_count++;
            $error("Retires not exactly 5 cycles apart");
        end

    no_retire_held: assert property (@(posedge clk) disable iff (rst)
        hold |=> !retire.valid)
        else begin
            fail_count++;
            $error("Retire seen while memories load");
        end

    ////////////////////////////////////////
    // Register 0
    ////////////////////////////////////////
    // Instruction register holds through FETCH, so rs_data must not move
    r0_write_stable: assert property (@(posedge clk) disable iff (rst)
        (rf_we && wr_addr == '0) |=> $stable(rs_data))
        else begin
            fail_count++;
            $error("Write to register 0 changed rs_data");
        end

endmodule

bind mips_core mips_core_asserts asserts_i (
    .clk(clk), .rst(rst), .hold(imem_load.en | dmem_load.en), .retire(retire),
    .rf_we(rf_we), .wr_addr(ctrl.dest), .rs_data(rs_data)
);

`default_nettype wire

//--- testbench/tb_mips_core.sv
// Testbench top for the multicycle MIPS core with program load and run report
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

    logic            clk = 1'b0;
    logic            rst;
    load_t           imem_load;
    load_t           dmem_load;
    retire_t         retire;
    int              checks;
    int              errors;
    logic [XLEN-1:0] img [IMEM_WORDS];   // Instruction image

    always #10 clk = ~clk;  // 20-unit period

    mips_core dut_i (
        .clk(clk), .rst(rst), .imem_load(imem_load), .dmem_load(dmem_load), .retire(retire)
    );

    mips_checker check_i (
        .clk(clk), .rst(rst), .imem_load(imem_load), .dmem_load(dmem_load),
        .retire(retire), .checks(checks), .errors(errors)
    );

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] encode_rtype(input logic [5:0] fn, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [4:0] rd,
                                                 input logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        logic [15:0] off_a;
        logic [15:0] off_b;
        off_a = {6'b0, 8'($urandom), 2'b00};  // Random word in DMEM
        off_b = off_a ^ 16'h0200;             // Different word, preloaded only
        for (int i = 0; i < IMEM_WORDS; i++) img[i] = {6'b111111, 18'h0, 8'(i)};  // Unlisted op
        img[0]  = encode_itype(OP_ADDI, 0, 1, 16'($urandom) | 16'h0001);  // Odd, never equals r3
        img[1]  = encode_itype(OP_ORI, 0, 2, 16'($urandom));
        img[2]  = encode_itype(OP_LUI, 0, 3, 16'($urandom));
        img[3]  = encode_rtype(FN_ADDU, 1, 2, 4, 0);
        img[4]  = encode_rtype(FN_SUB, 1, 3, 5, 0);
        img[5]  = encode_rtype(FN_SLT, 1, 2, 6, 0);
        img[6]  = encode_rtype(FN_SLTU, 3, 1, 7, 0);
        img[7]  = encode_rtype(FN_SLL, 0, 4, 8, 5'($urandom));
        img[8]  = encode_rtype(FN_SRL, 0, 3, 9, 5'($urandom));
        img[9]  = encode_itype(OP_ANDI, 4, 10, 16'($urandom));
        img[10] = encode_itype(OP_XORI, 5, 11, 16'($urandom));
        img[11] = encode_itype(OP_SLTI, 1, 12, 16'($urandom));
        img[12] = encode_itype(OP_SLTIU, 2, 13, 16'($urandom));
        img[13] = encode_itype(OP_SW, 0, 4, off_a);
        img[14] = encode_itype(OP_LW, 0, 14, off_a);   // Reads back r4
        img[15] = encode_itype(OP_LW, 0, 15, off_b);
        img[16] = encode_itype(OP_ADDI, 0, 0, 16'($urandom) | 16'h0001);  // Dropped write to r0
        img[17] = encode_rtype(FN_ADDU, 0, 0, 16, 0);
        img[18] = encode_itype(OP_BEQ, 14, 4, 16'd1);  // Taken
        img[20] = encode_itype(OP_BNE, 14, 4, 16'd1);  // Not taken
        img[21] = encode_itype(OP_BNE, 1, 3, 16'd1);   // Taken
        img[23] = encode_itype(OP_BEQ, 1, 3, 16'd1);   // Not taken
        img[24] = {OP_JAL, 26'd28};
        img[25] = {OP_J, 26'd31};                      // Return lands here
        img[28] = encode_itype(OP_ADDI, 31, 19, 16'h0);
        img[29] = encode_rtype(FN_JR, 31, 0, 0, 0);
        img[32] = encode_rtype(FN_ADDU, 19, 0, 20, 0);
    endtask

    ////////////////////////////////////////
    // Reset, load, run and report
    ////////////////////////////////////////
    initial begin
        int   cycles;
        logic timed_out;
        void'($urandom(32'h85e2));
        rst       = 1'b1;
        imem_load = '0;
        dmem_load = '0;
        build_program();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;  // Straight into loading, core stays parked
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem_load = '{en: 1'b1, we: 1'b1, addr: XLEN'(i) << 2, data: img[i]};
            dmem_load = '{en: 1'b1, we: 1'b1, addr: XLEN'(i) << 2, data: $urandom};
            @(posedge clk);
            #1;
        end
        imem_load = '0;
        dmem_load = '0;
        cycles    = 0;
        while (checks < 32 && cycles < 400) begin  // 32 retires, 160 cycles nominal
            @(posedge clk);
            #1;
            cycles++;
        end
        timed_out = (checks < 32);
        repeat (2) @(posedge clk);
        if (timed_out) $display("Timeout: only %0d of 32 retires seen", checks);
        $display("Retires checked: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, dut_i.asserts_i.fail_count);
        if (!timed_out && errors == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_core.f
rtl/mips_pkg.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/word_memory.sv
rtl/stage_sequencer.sv
rtl/mips_core.sv
testbench/mips_checker.sv
testbench/mips_core_asserts.sv
testbench/tb_mips_core.sv
